/* Makefile */
# Verilator build and run for the SECDED memory testbench

VERILATOR ?= verilator
TOP       ?= ecc_mem_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
common/ecc_pkg.sv
hdl/hamming_encoder.sv
hdl/hamming_decoder.sv
ecc_mem/ecc_storage.sv
ecc_mem/ecc_mem_ctrl.sv
hdl/ecc_mem_top.sv
dv/ecc_mem_tb.sv

/* common/ecc_pkg.sv */
package ecc_pkg;

	// Default geometry of the protected memory
	parameter int DEFAULT_DATA_BITS = 64;
	parameter int DEFAULT_ADDR_BITS = 4;

	// Read result as seen by the host
	typedef enum logic [1:0] {
		ECC_OK,
		ECC_CORRECTED,
		ECC_UNCORRECTABLE
	} ecc_status_t;

	// Hamming check bits, one per syndrome bit
	function automatic int fec_bits(input int data_bits);
		return $clog2(data_bits) + 1;
	endfunction

	// Data plus check bits plus the global parity bit at position 0
	function automatic int block_bits(input int data_bits);
		return data_bits + fec_bits(data_bits) + 1;
	endfunction

	// Codeword position of data bit idx
	// Walks up from 3 and skips the powers of two, which hold check bits
	function automatic int data_pos(input int data_bits, input int idx);
		int pos;
		int cnt;
		pos = 0;
		cnt = 0;
		for (int p = 3; p < block_bits(data_bits); p++) begin
			if ((p & (p - 1)) != 0) begin
				if (cnt == idx)
					pos = p;
				cnt = cnt + 1;
			end
		end
		return pos;
	endfunction

endpackage

/* dv/ecc_mem_tb.sv */
`timescale 1ns/1ps

module ecc_mem_tb;

	localparam int DATA_BITS = 64;
	localparam int ADDR_BITS = 4;
	localparam int BLOCK_BITS = ecc_pkg::block_bits(DATA_BITS);
	localparam int DEPTH = 2**ADDR_BITS;
	localparam int CLK_PERIOD = 20;
	localparam int RD_LATENCY = 3;
	localparam int RD_WAIT_MAX = 10;
	localparam int DOUBLE_PAIRS = 12;
	// Cycle budget with a write at 2 cycles and a lone read at about 6
	localparam int TEST_CYCLES = 12 + DEPTH * 8 + BLOCK_BITS * 8 + DOUBLE_PAIRS * 8 + 50
		+ DEPTH * 2 + DEPTH * 2 + 10;
	localparam int WATCHDOG_NS = TEST_CYCLES * 3 * CLK_PERIOD;

	logic clk;
	logic rst;
	logic wr_en;
	logic rd_en;
	logic [ADDR_BITS-1:0] addr;
	logic [DATA_BITS-1:0] wr_data;
	logic [BLOCK_BITS-1:0] inj_mask;
	logic scrub_en;
	logic rd_valid;
	logic [DATA_BITS-1:0] rd_data;
	ecc_pkg::ecc_status_t rd_status;
	logic [15:0] corr_count;
	logic [15:0] uncorr_count;

	integer seed;
	int errors;
	// Counter values the DUT should show
	int exp_corr;
	int exp_uncorr;
	// Reference copy of what each address should return
	logic [DATA_BITS-1:0] model_data [DEPTH];
	ecc_pkg::ecc_status_t model_stat [DEPTH];
	// Address order for the next read burst
	logic [ADDR_BITS-1:0] burst_addr [2*DEPTH];

	ecc_mem_top #(.DATA_BITS(DATA_BITS), .ADDR_BITS(ADDR_BITS)) ecc_mem_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// Hard stop in case a wait loop never returns
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, simulation did not finish", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	task automatic check_val(input string name, input logic [127:0] actual,
			input logic [127:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
				$time);
			errors++;
		end
	endtask

	function automatic logic [DATA_BITS-1:0] rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic logic [BLOCK_BITS-1:0] one_hot(input int pos);
		return BLOCK_BITS'(1) << pos;
	endfunction

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
	endtask

	// Host write that also records the status a later read should report
	task automatic write_word(input logic [ADDR_BITS-1:0] a, input logic [DATA_BITS-1:0] d,
			input logic [BLOCK_BITS-1:0] mask, input ecc_pkg::ecc_status_t st);
		@(posedge clk);
		wr_en <= 1'b1;
		addr <= a;
		wr_data <= d;
		inj_mask <= mask;
		@(posedge clk);
		wr_en <= 1'b0;
		inj_mask <= '0;
		model_data[a] = d;
		model_stat[a] = st;
	endtask

	// Compare one returned word against the model
	task automatic check_result(input logic [ADDR_BITS-1:0] a);
		if (model_stat[a] == ecc_pkg::ECC_CORRECTED)
			exp_corr++;
		if (model_stat[a] == ecc_pkg::ECC_UNCORRECTABLE)
			exp_uncorr++;
		check_val($sformatf("rd_status[%0d]", a), rd_status, model_stat[a]);
		// Data after a double flip is meaningless
		if (model_stat[a] != ecc_pkg::ECC_UNCORRECTABLE)
			check_val($sformatf("rd_data[%0d]", a), rd_data, model_data[a]);
		check_val("corr_count", corr_count, exp_corr);
		check_val("uncorr_count", uncorr_count, exp_uncorr);
	endtask

	// Back-to-back reads with results in order one per cycle
	task automatic read_burst(input int n);
		int lat;
		fork
			begin
				for (int i = 0; i < n; i++) begin
					@(posedge clk);
					rd_en <= 1'b1;
					addr <= burst_addr[i];
				end
				@(posedge clk);
				rd_en <= 1'b0;
			end
			begin
				// Cycle zero is the edge that samples the first rd_en
				@(posedge clk);
				@(posedge clk);
				@(negedge clk);
				lat = 0;
				while (!rd_valid && lat < RD_WAIT_MAX) begin
					@(negedge clk);
					lat++;
				end
				if (!rd_valid) begin
					$display("No rd_valid within %0d cycles of a read to address %0d",
						RD_WAIT_MAX, burst_addr[0]);
					errors++;
				end else begin
					check_val("read latency", lat, RD_LATENCY);
					for (int i = 0; i < n; i++) begin
						if (i > 0)
							@(negedge clk);
						if (!rd_valid) begin
							$display("rd_valid missing for read %0d of a burst of %0d", i, n);
							errors++;
						end else begin
							check_result(burst_addr[i]);
						end
					end
				end
			end
		join
	endtask

	task automatic read_one(input logic [ADDR_BITS-1:0] a);
		burst_addr[0] = a;
		read_burst(1);
	endtask

	task automatic test_clean_round_trip();
		for (int a = 0; a < DEPTH; a++)
			write_word(a, rand_word(), '0, ecc_pkg::ECC_OK);
		for (int a = 0; a < DEPTH; a++)
			read_one(a);
	endtask

	// Every code position including the parity bit
	task automatic test_single_correction();
		for (int p = 0; p < BLOCK_BITS; p++) begin
			write_word(p % DEPTH, rand_word(), one_hot(p), ecc_pkg::ECC_CORRECTED);
			read_one(p % DEPTH);
		end
	endtask

	task automatic test_double_detection();
		int p1;
		int p2;
		for (int k = 0; k < DOUBLE_PAIRS; k++) begin
			p1 = {$random(seed)} % BLOCK_BITS;
			// Offset from 1 to BLOCK_BITS-1 keeps the second bit distinct
			p2 = (p1 + 1 + {$random(seed)} % (BLOCK_BITS - 1)) % BLOCK_BITS;
			write_word(k % DEPTH, rand_word(), one_hot(p1) | one_hot(p2),
				ecc_pkg::ECC_UNCORRECTABLE);
			read_one(k % DEPTH);
		end
	endtask

	task automatic test_scrub();
		@(posedge clk);
		scrub_en <= 1'b1;
		write_word(5, rand_word(), one_hot(37), ecc_pkg::ECC_CORRECTED);
		read_one(5);
		// Scrub write-back should have cleaned the stored word
		model_stat[5] = ecc_pkg::ECC_OK;
		idle(4);
		read_one(5);
		@(posedge clk);
		scrub_en <= 1'b0;
		write_word(9, rand_word(), one_hot(0), ecc_pkg::ECC_CORRECTED);
		read_one(9);
		idle(4);
		// Without scrub the flip stays in storage
		read_one(9);
	endtask

	task automatic test_pipelined_reads();
		for (int a = 0; a < DEPTH; a++) begin
			if (a % 2 == 1)
				write_word(a, rand_word(), one_hot({$random(seed)} % BLOCK_BITS),
					ecc_pkg::ECC_CORRECTED);
			else
				write_word(a, rand_word(), '0, ecc_pkg::ECC_OK);
		end
		// Stride 7 visits every address twice in a shuffled order
		for (int i = 0; i < 2 * DEPTH; i++)
			burst_addr[i] = (i * 7) % DEPTH;
		read_burst(2 * DEPTH);
	endtask

	initial begin
		seed = 74;
		errors = 0;
		exp_corr = 0;
		exp_uncorr = 0;
		rst = 1'b1;
		wr_en = 1'b0;
		rd_en = 1'b0;
		addr = '0;
		wr_data = '0;
		inj_mask = '0;
		scrub_en = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		idle(2);
		test_clean_round_trip();
		test_single_correction();
		test_double_detection();
		test_scrub();
		test_pipelined_reads();
		idle(4);
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* ecc_mem/ecc_mem_ctrl.sv */
`timescale 1ns/1ps

module ecc_mem_ctrl #(
	parameter int DATA_BITS = ecc_pkg::DEFAULT_DATA_BITS,
	parameter int ADDR_BITS = ecc_pkg::DEFAULT_ADDR_BITS,
	localparam int BLOCK_BITS = ecc_pkg::block_bits(DATA_BITS)
)(
	input logic clk,
	input logic rst,
	input logic wr_en,
	input logic rd_en,
	input logic [ADDR_BITS-1:0] addr,
	input logic [DATA_BITS-1:0] wr_data,
	input logic [BLOCK_BITS-1:0] inj_mask,
	input logic scrub_en,
	input logic code_valid,
	input logic dec_valid,
	input logic [DATA_BITS-1:0] dec_data,
	input logic correctable_err,
	input logic uncorrectable_err,
	output logic enc_en,
	output logic [DATA_BITS-1:0] enc_data,
	output logic mem_we,
	output logic [ADDR_BITS-1:0] mem_waddr,
	output logic [BLOCK_BITS-1:0] mem_inj,
	output logic mem_re,
	output logic [ADDR_BITS-1:0] mem_raddr,
	output logic rd_valid,
	output logic [DATA_BITS-1:0] rd_data,
	output ecc_pkg::ecc_status_t rd_status,
	output logic [15:0] corr_count,
	output logic [15:0] uncorr_count
);

	// Write side, stage 1 sits beside the encoder input
	logic [ADDR_BITS-1:0] enc_addr;
	logic enc_host;
	logic [BLOCK_BITS-1:0] enc_mask;
	// Stage 2 sits beside the encoder output
	logic [ADDR_BITS-1:0] code_addr;
	logic code_host;
	logic [BLOCK_BITS-1:0] code_mask;
	// One-entry scrub holding register
	logic pend_valid;
	logic [DATA_BITS-1:0] pend_data;
	logic [ADDR_BITS-1:0] pend_addr;
	// Read address beside storage output and decoder output
	logic [ADDR_BITS-1:0] rcode_addr;
	logic [ADDR_BITS-1:0] dec_addr;
	logic scrub_req;
	ecc_pkg::ecc_status_t dec_status;

	// Corrected word goes back to where it came from
	assign scrub_req = scrub_en && dec_valid && correctable_err;

	always_ff @(posedge clk) begin
		if (rst) begin
			enc_en <= 1'b0;
			pend_valid <= 1'b0;
		end else begin
			enc_en <= wr_en || scrub_req || pend_valid;
			// Host write wins, scrub parks unless the host is overwriting that word
			if (wr_en)
				pend_valid <= scrub_req ? (dec_addr != addr) : (pend_valid && (pend_addr != addr));
			else
				pend_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			enc_data <= wr_data;
			enc_addr <= addr;
			enc_host <= 1'b1;
			enc_mask <= inj_mask;
		end else if (scrub_req) begin
			// Newer scrub goes first, an older pending one is dropped
			enc_data <= dec_data;
			enc_addr <= dec_addr;
			enc_host <= 1'b0;
		end else if (pend_valid) begin
			enc_data <= pend_data;
			enc_addr <= pend_addr;
			enc_host <= 1'b0;
		end
		if (scrub_req) begin
			pend_data <= dec_data;
			pend_addr <= dec_addr;
		end
		code_addr <= enc_addr;
		code_host <= enc_host;
		code_mask <= enc_mask;
	end

	assign mem_we = code_valid;
	assign mem_waddr = code_addr;
	// Injection only on host writes so a scrub stores a clean word
	assign mem_inj = code_host ? code_mask : '0;

	// Read issue plus address tracking for the scrub target
	always_ff @(posedge clk) begin
		if (rst)
			mem_re <= 1'b0;
		else
			mem_re <= rd_en;
		mem_raddr <= addr;
		rcode_addr <= mem_raddr;
		dec_addr <= rcode_addr;
	end

	always_comb begin
		if (correctable_err)
			dec_status = ecc_pkg::ECC_CORRECTED;
		else if (uncorrectable_err)
			dec_status = ecc_pkg::ECC_UNCORRECTABLE;
		else
			dec_status = ecc_pkg::ECC_OK;
	end

	// Counters move in the same cycle rd_valid shows the status
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid <= 1'b0;
			corr_count <= '0;
			uncorr_count <= '0;
		end else begin
			rd_valid <= dec_valid;
			if (dec_valid && correctable_err && (corr_count != '1))
				corr_count <= corr_count + 16'd1;
			if (dec_valid && uncorrectable_err && (uncorr_count != '1))
				uncorr_count <= uncorr_count + 16'd1;
		end
		rd_data <= dec_data;
		rd_status <= dec_status;
	end

	a_no_rd_wr: assert property (@(posedge clk) disable iff (rst) !(wr_en && rd_en));
	// Address pipeline and encoder latency stay in step
	a_we_align: assert property (@(posedge clk) disable iff (rst) mem_we == $past(enc_en));

endmodule

/* ecc_mem/ecc_storage.sv */
`timescale 1ns/1ps

module ecc_storage #(
	parameter int DATA_BITS = ecc_pkg::DEFAULT_DATA_BITS,
	parameter int ADDR_BITS = ecc_pkg::DEFAULT_ADDR_BITS,
	localparam int BLOCK_BITS = ecc_pkg::block_bits(DATA_BITS)
)(
	input logic clk,
	input logic rst,
	input logic mem_we,
	input logic [ADDR_BITS-1:0] mem_waddr,
	input logic [BLOCK_BITS-1:0] mem_wcode,
	input logic [BLOCK_BITS-1:0] mem_inj,
	input logic mem_re,
	input logic [ADDR_BITS-1:0] mem_raddr,
	output logic mem_rvalid,
	output logic [BLOCK_BITS-1:0] mem_rcode
);

	// One codeword per address
	logic [BLOCK_BITS-1:0] mem [2**ADDR_BITS];

	// Injected flips go into the stored word, the encoder output is untouched
	always_ff @(posedge clk) begin
		if (mem_we)
			mem[mem_waddr] <= mem_wcode ^ mem_inj;
	end

	// Registered read port
	always_ff @(posedge clk) begin
		if (rst)
			mem_rvalid <= 1'b0;
		else
			mem_rvalid <= mem_re;
		if (mem_re)
			mem_rcode <= mem[mem_raddr];
	end

endmodule

/* hdl/ecc_mem_top.sv */
`timescale 1ns/1ps

module ecc_mem_top #(
	parameter int DATA_BITS = ecc_pkg::DEFAULT_DATA_BITS,
	parameter int ADDR_BITS = ecc_pkg::DEFAULT_ADDR_BITS,
	localparam int BLOCK_BITS = ecc_pkg::block_bits(DATA_BITS)
)(
	input logic clk,
	input logic rst,
	input logic wr_en,
	input logic rd_en,
	input logic [ADDR_BITS-1:0] addr,
	input logic [DATA_BITS-1:0] wr_data,
	input logic [BLOCK_BITS-1:0] inj_mask,
	input logic scrub_en,
	output logic rd_valid,
	output logic [DATA_BITS-1:0] rd_data,
	output ecc_pkg::ecc_status_t rd_status,
	output logic [15:0] corr_count,
	output logic [15:0] uncorr_count
);

	// Encoder links
	logic enc_en;
	logic [DATA_BITS-1:0] enc_data;
	logic code_valid;
	logic [BLOCK_BITS-1:0] code;
	// Storage links
	logic mem_we;
	logic [ADDR_BITS-1:0] mem_waddr;
	logic [BLOCK_BITS-1:0] mem_inj;
	logic mem_re;
	logic [ADDR_BITS-1:0] mem_raddr;
	logic mem_rvalid;
	logic [BLOCK_BITS-1:0] mem_rcode;
	// Decoder links
	logic dec_valid;
	logic [DATA_BITS-1:0] dec_data;
	logic correctable_err;
	logic uncorrectable_err;

	ecc_mem_ctrl #(.DATA_BITS(DATA_BITS), .ADDR_BITS(ADDR_BITS)) ctrl_inst (.*);

	hamming_encoder #(.DATA_BITS(DATA_BITS)) encoder_inst (
		.clk(clk), .rst(rst), .enc_en(enc_en), .enc_data(enc_data),
		.code_valid(code_valid), .code(code)
	);

	ecc_storage #(.DATA_BITS(DATA_BITS), .ADDR_BITS(ADDR_BITS)) storage_inst (
		.clk(clk), .rst(rst), .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wcode(code),
		.mem_inj(mem_inj), .mem_re(mem_re), .mem_raddr(mem_raddr),
		.mem_rvalid(mem_rvalid), .mem_rcode(mem_rcode)
	);

	hamming_decoder #(.DATA_BITS(DATA_BITS)) decoder_inst (
		.clk(clk), .rst(rst), .valid_in(mem_rvalid), .data_in(mem_rcode),
		.valid_out(dec_valid), .data_out(dec_data),
		.correctable_err(correctable_err), .uncorrectable_err(uncorrectable_err)
	);

endmodule

/* hdl/hamming_decoder.sv */
`timescale 1ns/1ps

module hamming_decoder #(
	parameter int DATA_BITS = ecc_pkg::DEFAULT_DATA_BITS,
	localparam int FEC_BITS = ecc_pkg::fec_bits(DATA_BITS),
	localparam int BLOCK_BITS = ecc_pkg::block_bits(DATA_BITS)
)(
	input logic clk,
	input logic rst,
	input logic valid_in,
	input logic [BLOCK_BITS-1:0] data_in,
	output logic valid_out,
	output logic [DATA_BITS-1:0] data_out,
	output logic correctable_err,
	output logic uncorrectable_err
);

	logic [FEC_BITS-1:0] syndrome;
	logic parity_err;
	logic [DATA_BITS-1:0] data_fixed;
	logic single_err;
	logic double_err;

	// Syndrome is the index of the flipped position for a single error
	// Recomputing over the check bits too folds in the stored values
	always_comb begin
		syndrome = '0;
		for (int i = 0; i < FEC_BITS; i++) begin
			for (int j = 1; j < BLOCK_BITS; j++) begin
				if (((j >> i) & 1) != 0)
					syndrome[i] = syndrome[i] ^ data_in[j];
			end
		end
	end

	// Stored parity plus all covered bits should reduce to zero
	assign parity_err = ^data_in;

	// Extract data, flipping the bit the syndrome points at
	always_comb begin
		for (int d = 0; d < DATA_BITS; d++) begin
			if (int'(syndrome) == ecc_pkg::data_pos(DATA_BITS, d))
				data_fixed[d] = ~data_in[ecc_pkg::data_pos(DATA_BITS, d)];
			else
				data_fixed[d] = data_in[ecc_pkg::data_pos(DATA_BITS, d)];
		end
	end

	// Odd number of flips means one flip
	// zero syndrome there is the parity bit itself, data already clean
	assign single_err = parity_err;
	// Even number of flips with a nonzero syndrome
	assign double_err = (syndrome != '0) && !parity_err;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_out <= 1'b0;
			correctable_err <= 1'b0;
			uncorrectable_err <= 1'b0;
		end else begin
			valid_out <= valid_in;
			correctable_err <= valid_in && single_err;
			uncorrectable_err <= valid_in && double_err;
		end
		data_out <= data_fixed;
	end

	// A single flip always points at a real code position
	a_syndrome_range: assert property (@(posedge clk) disable iff (rst)
		valid_in && parity_err |-> int'(syndrome) < BLOCK_BITS);

endmodule

/* hdl/hamming_encoder.sv */
`timescale 1ns/1ps

module hamming_encoder #(
	parameter int DATA_BITS = ecc_pkg::DEFAULT_DATA_BITS,
	localparam int FEC_BITS = ecc_pkg::fec_bits(DATA_BITS),
	localparam int BLOCK_BITS = ecc_pkg::block_bits(DATA_BITS)
)(
	input logic clk,
	input logic rst,
	input logic enc_en,
	input logic [DATA_BITS-1:0] enc_data,
	output logic code_valid,
	output logic [BLOCK_BITS-1:0] code
);

	// Data bits at their code positions, check and parity slots still zero
	logic [BLOCK_BITS-1:0] placed;
	logic [BLOCK_BITS-1:0] code_next;

	always_comb begin
		placed = '0;
		for (int d = 0; d < DATA_BITS; d++)
			placed[ecc_pkg::data_pos(DATA_BITS, d)] = enc_data[d];

		code_next = placed;
		// Check bit i covers every position with bit i set in its index
		for (int i = 0; i < FEC_BITS; i++) begin
			for (int j = (1 << i) + 1; j < BLOCK_BITS; j++) begin
				if (((j >> i) & 1) != 0)
					code_next[1 << i] = code_next[1 << i] ^ placed[j];
			end
		end

		// Global parity over everything above it, check bits included
		code_next[0] = ^code_next[BLOCK_BITS-1:1];
	end

	always_ff @(posedge clk) begin
		if (rst)
			code_valid <= 1'b0;
		else
			code_valid <= enc_en;
		// Codeword only loads on a request
		if (enc_en)
			code <= code_next;
	end

endmodule
